// ==== bench/tb_vec_issue.sv ====
// testbench for the vector issue front end
// clock, reset, instruction stimulus, in-flight writer model and checking assertions
`timescale 1ns/1ps
`default_nettype none

module tb_vec_issue;

  import vec_isa_pkg::*;
  import vec_pipe_pkg::*;

  logic            clk;
  logic            rst_n;
  logic            hold;
  instr_t          instr;
  unit_results_t   unit_results;
  rf_read_t        rf_data;
  logic            valid_op;
  logic            busy;
  dispatch_t       dispatch;
  operand_bundle_t operands;

  dispatch_t       exp_cand;                 // decode expected for the word on instr
  dispatch_t       exp_disp;
  operand_bundle_t exp_stage;
  operand_bundle_t exp_ops;
  sb_entry_t       model_sb [2*SB_DEPTH];
  logic            model_busy;
  logic            model_accept;
  int              free_slot;
  int              cyc;
  int              errors;
  int              n_accepted;
  logic            aborted;
  string           test_name;

  vec_issue_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .hold         (hold),
    .unit_results (unit_results),
    .rf_data      (rf_data),
    .valid_op     (valid_op),
    .busy         (busy),
    .dispatch     (dispatch),
    .operands     (operands)
  );

  //==============================
  // stimulus helpers
  //==============================
  function automatic logic [VEC_W-1:0] bus_word(input int c, input unit_e u);
    return {32'(c), 30'd0, u, 32'hfeed_0000, 32'(c) ^ 32'h5a5a_5a5a};
  endfunction

  function automatic logic [VEC_W-1:0] rf_pattern(input vreg_t r);
    return {4{r, 27'h5a0c3e1}};
  endfunction

  function automatic logic [2:0] lat_of(input unit_e u);
    logic [2:0] lat;
    lat = 3'(LAT_FLOAT);
    if (u == UNIT_LOAD)
      lat = 3'(LAT_LOAD);
    else if (u == UNIT_PERM)
      lat = 3'(LAT_PERM);
    else if (u == UNIT_SIMPLE)
      lat = 3'(LAT_SIMPLE);
    return lat;
  endfunction

  // kinds 0 to 10 are lvx lvebx vmrghb vmrglb vpkuhum vaddubm vsububm vand vaddfp vsubfp vmaddfp
  function automatic void build_op(input int kind, input vreg_t vd, input vreg_t va,
                                   input vreg_t vb, input vreg_t vc,
                                   output logic [31:0] word, output dispatch_t exp);
    logic [10:0] xo;
    unit_e       u;
    xo = 11'd0;
    u  = UNIT_FLOAT;
    case (kind)
      2: xo = XO_VMRGHB;
      3: xo = XO_VMRGLB;
      4: xo = XO_VPKUHUM;
      5: xo = XO_VADDUBM;
      6: xo = XO_VSUBUBM;
      7: xo = XO_VAND;
      8: xo = XO_VADDFP;
      9: xo = XO_VSUBFP;
      default: xo = 11'd0;
    endcase
    if (kind >= 2 && kind <= 4)
      u = UNIT_PERM;
    else if (kind >= 5 && kind <= 7)
      u = UNIT_SIMPLE;
    exp        = '0;
    exp.valid  = 1'b1;
    exp.target = vd;
    exp.src_a  = va;
    exp.src_b  = vb;
    if (kind <= 1)
    begin
      xo          = (kind == 0) ? {XO_LVX, 1'b0} : {XO_LVEBX, 1'b0};
      word        = {OPC_EXT, vd, va, vb, xo};
      exp.unit    = UNIT_LOAD;
      exp.op_type = {1'b0, xo[10:1]};            // loads read no vector regs
    end
    else if (kind == 10)
    begin
      word        = {OPC_VECTOR, vd, va, vb, vc, XO_VMADDFP};
      exp.unit    = UNIT_FLOAT;
      exp.op_type = {5'd0, XO_VMADDFP};
      exp.rd_a    = 1'b1;
      exp.rd_b    = 1'b1;
      exp.rd_c    = 1'b1;
    end
    else
    begin
      word        = {OPC_VECTOR, vd, va, vb, xo};
      exp.unit    = u;
      exp.op_type = xo;
      exp.rd_a    = 1'b1;
      exp.rd_b    = 1'b1;
    end
    exp.src_c = word[10:6];                      // C field of the va form
  endfunction

  // rule for one source at accept time
  function automatic logic [VEC_W-1:0] operand_expect(input logic rd, input vreg_t src);
    logic [VEC_W-1:0] val;
    val = '0;
    if (rd)
    begin
      val = rf_pattern(src);
      for (int i = 0; i < 2*SB_DEPTH; i++)
        if (model_sb[i].valid && model_sb[i].target == src && model_sb[i].cnt == 3'd1)
          val = bus_word(cyc + 1, model_sb[i].unit);   // bus carries it next cycle
    end
    return val;
  endfunction

  task automatic report_value(input string what, input logic [VEC_W-1:0] exp_val,
                              input logic [VEC_W-1:0] act_val);
    errors++;
    $display("Error: %s %s expected %h got %h", test_name, what, exp_val, act_val);
  endtask

  task automatic step_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic issue(input int kind, input vreg_t vd, input vreg_t va, input vreg_t vb,
                       input vreg_t vc, input int limit);
    logic [31:0] word;
    dispatch_t   exp;
    int          n;
    build_op(kind, vd, va, vb, vc, word, exp);
    instr    = word;
    exp_cand = exp;
    n        = 0;
    #1;
    while ((busy || hold) && n < limit && !aborted)
    begin
      @(posedge clk);
      #11;
      n++;
    end
    if ((busy || hold) && !aborted)
    begin
      errors++;
      aborted = 1'b1;
      $display("Timeout in %s: instruction %h still stalled after %0d cycles",
               test_name, word, n);
    end
    @(posedge clk);
    #10;
    instr    = '0;
    exp_cand = '0;
  endtask

  task automatic present_junk();
    logic [31:0] word;
    word = $urandom;
    if (word[31:26] == OPC_VECTOR || word[31:26] == OPC_EXT)
      word[31:26] = 6'd0;
    instr    = word;
    exp_cand = '0;
    step_cycles(1);
    instr = '0;
  endtask

  task automatic wait_operands(input int limit);
    int n;
    n = 0;
    while (!operands.valid && n < limit && !aborted)
    begin
      step_cycles(1);
      n++;
    end
    if (!operands.valid && !aborted)
    begin
      errors++;
      aborted = 1'b1;
      $display("Timeout in %s: no operands delivered within %0d cycles", test_name, n);
    end
  endtask

  //==============================
  // clock, result buses, register file
  //==============================
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    cyc = 0;
    forever
    begin
      unit_results = '{ld: bus_word(cyc, UNIT_LOAD), perm: bus_word(cyc, UNIT_PERM),
                       simple: bus_word(cyc, UNIT_SIMPLE), fp: bus_word(cyc, UNIT_FLOAT)};
      rf_data      = '{a: rf_pattern(dispatch.src_a), b: rf_pattern(dispatch.src_b),
                       c: rf_pattern(dispatch.src_c)};
      @(posedge clk);
      #10;
      cyc = cyc + 1;
    end
  end

  //==============================
  // reference model
  //==============================
  always_comb
  begin
    model_busy = 1'b0;
    free_slot  = 0;
    for (int i = 2*SB_DEPTH - 1; i >= 0; i--)
    begin
      if (!model_sb[i].valid)
        free_slot = i;
      if (model_sb[i].valid && exp_cand.valid)
      begin
        if (model_sb[i].cnt > 3'd1 &&
            ((exp_cand.rd_a && exp_cand.src_a == model_sb[i].target) ||
             (exp_cand.rd_b && exp_cand.src_b == model_sb[i].target) ||
             (exp_cand.rd_c && exp_cand.src_c == model_sb[i].target)))
          model_busy = 1'b1;   // read after write
        if (model_sb[i].target == exp_cand.target && model_sb[i].cnt >= lat_of(exp_cand.unit))
          model_busy = 1'b1;   // write after write
      end
    end
  end

  assign model_accept = exp_cand.valid && !hold && !model_busy;

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 2*SB_DEPTH; i++)
        model_sb[i] <= '0;
      exp_disp   <= '0;
      exp_stage  <= '0;
      exp_ops    <= '0;
      n_accepted <= 0;
    end
    else
    begin
      for (int i = 0; i < 2*SB_DEPTH; i++)
      begin
        if (model_sb[i].valid)
        begin
          model_sb[i].cnt <= model_sb[i].cnt - 3'd1;
          if (model_sb[i].cnt == 3'd1)
            model_sb[i].valid <= 1'b0;
        end
      end
      exp_ops <= exp_stage;
      if (model_accept)
      begin
        model_sb[free_slot] <= '{valid: 1'b1, target: exp_cand.target, unit: exp_cand.unit,
                                 cnt: lat_of(exp_cand.unit)};
        exp_disp   <= exp_cand;
        exp_stage  <= '{valid: 1'b1, a: operand_expect(exp_cand.rd_a, exp_cand.src_a),
                        b: operand_expect(exp_cand.rd_b, exp_cand.src_b),
                        c: operand_expect(exp_cand.rd_c, exp_cand.src_c)};
        n_accepted <= n_accepted + 1;
      end
      else
      begin
        exp_disp.valid <= 1'b0;
        exp_stage      <= '0;
      end
    end
  end

  //==============================
  // checks
  //==============================
  a_valid_op : assert property (@(posedge clk) disable iff (!rst_n)
    valid_op == exp_cand.valid)
    else report_value("valid_op", 128'(exp_cand.valid), 128'(valid_op));

  a_busy : assert property (@(posedge clk) disable iff (!rst_n) busy == model_busy)
    else report_value("busy", 128'(model_busy), 128'(busy));

  a_disp_valid : assert property (@(posedge clk) disable iff (!rst_n)
    dispatch.valid == exp_disp.valid)
    else report_value("dispatch.valid", 128'(exp_disp.valid), 128'(dispatch.valid));

  a_disp_fields : assert property (@(posedge clk) disable iff (!rst_n)
    dispatch.valid |-> dispatch == exp_disp)
    else report_value("dispatch", 128'(exp_disp), 128'(dispatch));

  a_hold : assert property (@(posedge clk) disable iff (!rst_n) hold |=> !dispatch.valid)
    else report_value("dispatch.valid under hold", 128'(1'b0), 128'(dispatch.valid));

  a_ops_valid : assert property (@(posedge clk) disable iff (!rst_n)
    operands.valid == exp_ops.valid)
    else report_value("operands.valid", 128'(exp_ops.valid), 128'(operands.valid));

  a_op_a : assert property (@(posedge clk) disable iff (!rst_n)
    operands.valid |-> operands.a == exp_ops.a)
    else report_value("operand a", exp_ops.a, operands.a);

  a_op_b : assert property (@(posedge clk) disable iff (!rst_n)
    operands.valid |-> operands.b == exp_ops.b)
    else report_value("operand b", exp_ops.b, operands.b);

  a_op_c : assert property (@(posedge clk) disable iff (!rst_n)
    operands.valid |-> operands.c == exp_ops.c)
    else report_value("operand c", exp_ops.c, operands.c);

  a_reset_state : assert property (@(posedge clk)
    !rst_n |=> (!dispatch.valid && !operands.valid && !busy))
    else
    begin
      errors++;
      $display("Reset state wrong: dispatch, operands or busy not low during reset");
    end

  //==============================
  // test sequence
  //==============================
  initial
  begin
    int kind;
    void'($urandom(32'hbd9d8ef7));
    errors     = 0;
    aborted    = 1'b0;
    test_name  = "reset";
    rst_n      = 1'b0;
    hold       = 1'b0;
    instr      = '0;
    exp_cand   = '0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;

    test_name = "classify";
    for (int k = 0; k < 11; k++)
      issue(k, vreg_t'(20 + k), vreg_t'(k), vreg_t'(k + 1), vreg_t'(k + 2), 8);
    repeat (6) present_junk();
    step_cycles(6);

    test_name = "hold";
    hold      = 1'b1;
    fork
      issue(3, 5'd14, 5'd15, 5'd16, 5'd0, 8);     // waits until hold drops
      begin
        step_cycles(3);
        hold = 1'b0;
      end
    join
    wait_operands(4);
    step_cycles(6);

    test_name = "raw_float";
    issue(8, 5'd5, 5'd1, 5'd2, 5'd0, 8);
    issue(7, 5'd6, 5'd5, 5'd3, 5'd0, 10);         // stalls until the fp countdown hits 1
    wait_operands(4);
    step_cycles(6);

    test_name = "forward";
    for (int j = 0; j < 3; j++)
    begin
      kind = (j == 0) ? 0 : (j == 1) ? 2 : 5;
      issue(kind, 5'd7, 5'd1, 5'd2, 5'd0, 8);
      issue(4, 5'd8, 5'd7, 5'd7, 5'd0, 8);        // lands at exactly the writer latency
      issue(kind, 5'd9, 5'd1, 5'd2, 5'd0, 8);
      issue(10, 5'd10, 5'd3, 5'd4, 5'd9, 8);       // C from the bus
      wait_operands(4);
      step_cycles(6);
      issue(6, 5'd11, 5'd7, 5'd9, 5'd0, 8);        // late consumer reads the RF
      wait_operands(4);
      step_cycles(6);
    end

    test_name = "waw";
    issue(9, 5'd12, 5'd1, 5'd2, 5'd0, 8);
    issue(1, 5'd12, 5'd3, 5'd4, 5'd0, 10);
    wait_operands(4);
    step_cycles(6);

    test_name = "random";
    for (int n = 0; n < 60; n++)
    begin
      kind = int'($urandom % 12);
      if (kind == 11)
        present_junk();
      else
        issue(kind, vreg_t'($urandom % 4), vreg_t'($urandom % 4), vreg_t'($urandom % 4),
              vreg_t'($urandom % 4), 10);
    end
    step_cycles(8);

    $display("Summary: %0d instructions accepted, %0d errors", n_accepted, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/vec_isa_pkg.sv
design/vec_pipe_pkg.sv
design/instr_decode_stage.sv
design/hazard_scoreboard.sv
design/operand_forward.sv
design/vec_issue_top.sv
bench/tb_vec_issue.sv

// ==== design/hazard_scoreboard.sv ====
// in-flight writer scoreboard
// raw and waw stall detection, forward source selection
`timescale 1ns/1ps
`default_nettype none

module hazard_scoreboard (
  input  logic                    clk,
  input  logic                    rst_n,
  input  vec_pipe_pkg::dispatch_t candidate,
  input  logic                    hold,
  output logic                    busy,
  output vec_pipe_pkg::fwd_sel_t  fwd_sel
);

  import vec_isa_pkg::*;
  import vec_pipe_pkg::*;

  sb_entry_t            entries  [SB_DEPTH];
  vreg_t                src      [3];
  logic                 rd       [3];
  logic                 fwd_hit  [3];
  unit_e                fwd_unit [3];
  logic [2:0]           new_lat;
  logic                 raw_hit;
  logic                 waw_hit;
  logic                 alloc;
  logic                 free_found;
  logic [SB_IDX_W-1:0]  free_idx;
  logic                 dup_found;

  assign src[0]  = candidate.src_a;
  assign src[1]  = candidate.src_b;
  assign src[2]  = candidate.src_c;
  assign rd[0]   = candidate.rd_a;
  assign rd[1]   = candidate.rd_b;
  assign rd[2]   = candidate.rd_c;
  assign new_lat = unit_lat(candidate.unit);

  //==============================
  // hazard compare
  //==============================
  always_comb
  begin
    raw_hit = 1'b0;
    waw_hit = 1'b0;
    for (int j = 0; j < 3; j++)
    begin
      fwd_hit[j]  = 1'b0;
      fwd_unit[j] = UNIT_LOAD;
    end
    for (int i = 0; i < SB_DEPTH; i++)
    begin
      if (entries[i].valid && candidate.valid)
      begin
        for (int j = 0; j < 3; j++)
        begin
          if (rd[j] && src[j] == entries[i].target)
          begin
            if (entries[i].cnt > 3'd1)
              raw_hit = 1'b1;   // result not yet on its bus
            else
            begin
              fwd_hit[j]  = 1'b1;   // bus carries it next cycle
              fwd_unit[j] = entries[i].unit;
            end
          end
        end
        if (entries[i].target == candidate.target && entries[i].cnt >= new_lat)
          waw_hit = 1'b1;
      end
    end
  end

  assign busy  = raw_hit | waw_hit;
  assign alloc = candidate.valid && !hold && !busy;

  // an entry reading 1 retires at this edge and may be reused
  always_comb
  begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = SB_DEPTH - 1; i >= 0; i--)
    begin
      if (!entries[i].valid || entries[i].cnt == 3'd1)
      begin
        free_found = 1'b1;
        free_idx   = SB_IDX_W'(i);
      end
    end
  end

  always_comb
  begin
    dup_found = 1'b0;
    for (int i = 0; i < SB_DEPTH; i++)
      for (int k = i + 1; k < SB_DEPTH; k++)
        if (entries[i].valid && entries[k].valid &&
            entries[i].target == entries[k].target && entries[i].cnt == entries[k].cnt)
          dup_found = 1'b1;
  end

  //==============================
  // entry update
  //==============================
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < SB_DEPTH; i++)
        entries[i] <= '0;
      fwd_sel <= '0;
    end
    else
    begin
      for (int i = 0; i < SB_DEPTH; i++)
      begin
        if (alloc && free_idx == SB_IDX_W'(i))
          entries[i] <= '{valid: 1'b1, target: candidate.target,
                          unit: candidate.unit, cnt: new_lat};
        else if (entries[i].valid)
        begin
          entries[i].cnt <= entries[i].cnt - 3'd1;
          if (entries[i].cnt == 3'd1)
            entries[i].valid <= 1'b0;
        end
      end
      if (alloc)
        fwd_sel <= '{fwd_a: fwd_hit[0], fwd_b: fwd_hit[1], fwd_c: fwd_hit[2],
                     unit_a: fwd_unit[0], unit_b: fwd_unit[1], unit_c: fwd_unit[2]};
      else
        fwd_sel <= '0;
    end
  end

  a_alloc_has_room : assert property (
    @(posedge clk) disable iff (!rst_n) alloc |-> free_found);

  // writers of one register must retire in distinct cycles
  a_waw_distinct : assert property (
    @(posedge clk) disable iff (!rst_n) !dup_found);

endmodule

`default_nettype wire

// ==== design/instr_decode_stage.sv ====
// instruction classification and register field extraction
// plus the registered dispatch record
`timescale 1ns/1ps
`default_nettype none

module instr_decode_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  vec_isa_pkg::instr_t     instr,
  input  logic                    hold,
  input  logic                    busy,
  output vec_pipe_pkg::dispatch_t candidate,
  output logic                    accept,
  output logic                    valid_op,
  output vec_pipe_pkg::dispatch_t dispatch
);

  import vec_isa_pkg::*;

  logic is_vec;
  logic is_load;
  logic is_perm;
  logic is_simple;
  logic is_madd;
  logic is_float;

  //==============================
  // predecode
  //==============================
  assign is_vec    = (instr.vx.opcd == OPC_VECTOR);
  assign is_load   = (instr.vx.opcd == OPC_EXT) &&
                     (instr.vx.xo[10:1] == XO_LVX || instr.vx.xo[10:1] == XO_LVEBX);
  assign is_perm   = is_vec && (instr.vx.xo == XO_VMRGHB || instr.vx.xo == XO_VMRGLB ||
                                instr.vx.xo == XO_VPKUHUM);
  assign is_simple = is_vec && (instr.vx.xo == XO_VADDUBM || instr.vx.xo == XO_VSUBUBM ||
                                instr.vx.xo == XO_VAND);
  assign is_madd   = is_vec && (instr.va.xo == XO_VMADDFP);
  assign is_float  = is_madd ||
                     (is_vec && (instr.vx.xo == XO_VADDFP || instr.vx.xo == XO_VSUBFP));

  always_comb
  begin
    candidate.valid  = is_load | is_perm | is_simple | is_float;
    if (is_load)
      candidate.unit = UNIT_LOAD;
    else if (is_perm)
      candidate.unit = UNIT_PERM;
    else if (is_simple)
      candidate.unit = UNIT_SIMPLE;
    else
      candidate.unit = UNIT_FLOAT;
    if (is_madd)
      candidate.op_type = {5'd0, instr.va.xo};
    else if (is_load)
      candidate.op_type = {1'b0, instr.vx.xo[10:1]};
    else
      candidate.op_type = instr.vx.xo;
    candidate.src_a  = instr.vx.va;
    candidate.src_b  = instr.vx.vb;
    candidate.src_c  = instr.va.vc;
    candidate.rd_a   = is_perm | is_simple | is_float;   // loads read no vector regs
    candidate.rd_b   = is_perm | is_simple | is_float;
    candidate.rd_c   = is_madd;
    candidate.target = instr.vx.vd;
  end

  assign valid_op = candidate.valid;
  assign accept   = candidate.valid && !hold && !busy;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      dispatch.valid <= 1'b0;
    else if (accept)
      dispatch <= candidate;
    else
      dispatch.valid <= 1'b0;   // one-cycle strobe
  end

  a_hold_blocks_dispatch : assert property (
    @(posedge clk) disable iff (!rst_n) hold |=> !dispatch.valid);

endmodule

`default_nettype wire

// ==== design/operand_forward.sv ====
// one source operand register
// picks a unit result bus, the register file word or zero
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          rd_en,
  input  logic                          fwd,
  input  vec_isa_pkg::unit_e            fwd_unit,
  input  vec_pipe_pkg::unit_results_t   unit_results,
  input  logic [vec_isa_pkg::VEC_W-1:0] rf_word,
  output logic [vec_isa_pkg::VEC_W-1:0] operand
);

  import vec_isa_pkg::*;

  logic [VEC_W-1:0] bus_word;

  always_comb
  begin
    case (fwd_unit)
      UNIT_LOAD:   bus_word = unit_results.ld;
      UNIT_PERM:   bus_word = unit_results.perm;
      UNIT_SIMPLE: bus_word = unit_results.simple;
      default:     bus_word = unit_results.fp;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (fwd)
      operand <= bus_word;   // result arrives this cycle
    else if (rd_en)
      operand <= rf_word;
    else
      operand <= '0;
  end

  // scoreboard flags only sources that the decoder enabled
  a_fwd_needs_read : assert property (
    @(posedge clk) disable iff (!rst_n) fwd |-> rd_en);

endmodule

`default_nettype wire

// ==== design/vec_isa_pkg.sv ====
// vector ISA definitions
// instruction formats, opcode tables, unit codes and unit latencies
`default_nettype none

package vec_isa_pkg;

  localparam int VEC_W = 128;

  typedef logic [4:0] vreg_t;

  // VX form, the indexed loads share this layout
  typedef struct packed {
    logic [5:0]  opcd;
    vreg_t       vd;
    vreg_t       va;
    vreg_t       vb;
    logic [10:0] xo;
  } vx_form_t;

  // VA form, third source in bits 21:25
  typedef struct packed {
    logic [5:0] opcd;
    vreg_t      vd;
    vreg_t      va;
    vreg_t      vb;
    vreg_t      vc;
    logic [5:0] xo;
  } va_form_t;

  typedef union packed {
    vx_form_t vx;
    va_form_t va;
  } instr_t;

  typedef enum logic [1:0] {
    UNIT_LOAD   = 2'd0,
    UNIT_PERM   = 2'd1,
    UNIT_SIMPLE = 2'd2,
    UNIT_FLOAT  = 2'd3
  } unit_e;

  localparam logic [5:0] OPC_VECTOR = 6'd4;
  localparam logic [5:0] OPC_EXT    = 6'd31;

  //==============================
  // extended opcodes
  //==============================
  localparam logic [9:0]  XO_LVX     = 10'd103;   // x-form, bits 21:30
  localparam logic [9:0]  XO_LVEBX   = 10'd7;
  localparam logic [10:0] XO_VMRGHB  = 11'd12;
  localparam logic [10:0] XO_VMRGLB  = 11'd268;
  localparam logic [10:0] XO_VPKUHUM = 11'd14;
  localparam logic [10:0] XO_VADDUBM = 11'd0;
  localparam logic [10:0] XO_VSUBUBM = 11'd1024;
  localparam logic [10:0] XO_VAND    = 11'd1028;
  localparam logic [10:0] XO_VADDFP  = 11'd10;
  localparam logic [10:0] XO_VSUBFP  = 11'd74;
  localparam logic [5:0]  XO_VMADDFP = 6'd46;     // va-form

  //==============================
  // latencies, dispatch to result bus
  //==============================
  localparam int LAT_LOAD   = 1;
  localparam int LAT_PERM   = 2;
  localparam int LAT_SIMPLE = 2;
  localparam int LAT_FLOAT  = 4;
  localparam int MAX_LAT    = 4;

  function automatic logic [2:0] unit_lat(unit_e u);
    case (u)
      UNIT_LOAD:   return 3'(LAT_LOAD);
      UNIT_PERM:   return 3'(LAT_PERM);
      UNIT_SIMPLE: return 3'(LAT_SIMPLE);
      default:     return 3'(LAT_FLOAT);
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== design/vec_issue_top.sv ====
// vector issue front end
// decode, hazard scoreboard and three operand selectors
`timescale 1ns/1ps
`default_nettype none

module vec_issue_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  vec_isa_pkg::instr_t           instr,
  input  logic                          hold,
  input  vec_pipe_pkg::unit_results_t   unit_results,
  input  vec_pipe_pkg::rf_read_t        rf_data,
  output logic                          valid_op,
  output logic                          busy,
  output vec_pipe_pkg::dispatch_t       dispatch,
  output vec_pipe_pkg::operand_bundle_t operands
);

  import vec_isa_pkg::*;
  import vec_pipe_pkg::*;

  dispatch_t        candidate;
  fwd_sel_t         fwd_sel;
  logic [VEC_W-1:0] op_a;
  logic [VEC_W-1:0] op_b;
  logic [VEC_W-1:0] op_c;
  logic             ops_valid;

  instr_decode_stage u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr     (instr),
    .hold      (hold),
    .busy      (busy),
    .candidate (candidate),
    .accept    (),
    .valid_op  (valid_op),
    .dispatch  (dispatch)
  );

  hazard_scoreboard u_scoreboard (
    .clk       (clk),
    .rst_n     (rst_n),
    .candidate (candidate),
    .hold      (hold),
    .busy      (busy),
    .fwd_sel   (fwd_sel)
  );

  //==============================
  // operand stage one cycle behind dispatch
  //==============================
  operand_forward u_fwd_a (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_en        (dispatch.valid & dispatch.rd_a),
    .fwd          (fwd_sel.fwd_a),
    .fwd_unit     (fwd_sel.unit_a),
    .unit_results (unit_results),
    .rf_word      (rf_data.a),
    .operand      (op_a)
  );

  operand_forward u_fwd_b (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_en        (dispatch.valid & dispatch.rd_b),
    .fwd          (fwd_sel.fwd_b),
    .fwd_unit     (fwd_sel.unit_b),
    .unit_results (unit_results),
    .rf_word      (rf_data.b),
    .operand      (op_b)
  );

  operand_forward u_fwd_c (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_en        (dispatch.valid & dispatch.rd_c),
    .fwd          (fwd_sel.fwd_c),
    .fwd_unit     (fwd_sel.unit_c),
    .unit_results (unit_results),
    .rf_word      (rf_data.c),
    .operand      (op_c)
  );

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      ops_valid <= 1'b0;
    else
      ops_valid <= dispatch.valid;
  end

  assign operands = '{valid: ops_valid, a: op_a, b: op_b, c: op_c};

endmodule

`default_nettype wire

// ==== design/vec_pipe_pkg.sv ====
// issue pipeline types
// dispatch record, forward select, scoreboard entry and operand buses
`default_nettype none

package vec_pipe_pkg;

  localparam int SB_DEPTH = vec_isa_pkg::MAX_LAT;
  localparam int SB_IDX_W = $clog2(SB_DEPTH);

  typedef struct packed {
    logic               valid;
    vec_isa_pkg::unit_e unit;
    logic [10:0]        op_type;
    vec_isa_pkg::vreg_t src_a;
    vec_isa_pkg::vreg_t src_b;
    vec_isa_pkg::vreg_t src_c;
    logic               rd_a;
    logic               rd_b;
    logic               rd_c;
    vec_isa_pkg::vreg_t target;
  } dispatch_t;

  typedef struct packed {
    logic               fwd_a;
    logic               fwd_b;
    logic               fwd_c;
    vec_isa_pkg::unit_e unit_a;
    vec_isa_pkg::unit_e unit_b;
    vec_isa_pkg::unit_e unit_c;
  } fwd_sel_t;

  typedef struct packed {
    logic               valid;
    vec_isa_pkg::vreg_t target;
    vec_isa_pkg::unit_e unit;
    logic [2:0]         cnt;     // cycles left until the result bus
  } sb_entry_t;

  typedef struct packed {
    logic [vec_isa_pkg::VEC_W-1:0] ld;
    logic [vec_isa_pkg::VEC_W-1:0] perm;
    logic [vec_isa_pkg::VEC_W-1:0] simple;
    logic [vec_isa_pkg::VEC_W-1:0] fp;
  } unit_results_t;

  typedef struct packed {
    logic [vec_isa_pkg::VEC_W-1:0] a;
    logic [vec_isa_pkg::VEC_W-1:0] b;
    logic [vec_isa_pkg::VEC_W-1:0] c;
  } rf_read_t;

  typedef struct packed {
    logic                          valid;
    logic [vec_isa_pkg::VEC_W-1:0] a;
    logic [vec_isa_pkg::VEC_W-1:0] b;
    logic [vec_isa_pkg::VEC_W-1:0] c;
  } operand_bundle_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vector issue testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_vec_issue -f compile.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_vec_issue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  exit 0
fi
echo "simulation reported failures"
exit 1
